// File: am_lock_pkg.sv
package am_lock_pkg;

	localparam int LEN_AM    = 48;     // six marker bytes, BIP bytes excluded
	localparam int N_ALIGNER = 20;     // lanes with a defined marker
	localparam int LANE_ID_W = 5;
	localparam int AM_PERIOD = 16384;  // valid blocks between markers
	localparam int TIMER_W   = 14;
	localparam int LOCK_GOOD = 2;      // good markers in a row to lock
	localparam int LOSS_BAD  = 4;      // bad markers in a row to lose lock

	// marker bytes M0, M1, M2, M4, M5, M6 with M0 in the top byte
	typedef logic [LEN_AM-1:0]    am_value_t;
	typedef logic [N_ALIGNER-1:0] lane_vec_t;
	typedef logic [LANE_ID_W-1:0] lane_id_t;
	typedef logic [63:0]          block_t;
	typedef logic [1:0]           sync_hdr_t;
	typedef logic [TIMER_W-1:0]   timer_t;

	typedef enum logic [1:0]
	{
		ST_SEARCH,   // hunting for any marker
		ST_CONFIRM,  // one marker seen, waiting one period
		ST_LOCKED,
		ST_INVALID   // locked, counting bad markers
	} lock_state_e;

	localparam sync_hdr_t SH_CTRL = 2'b10;

	// lane 0 first
	localparam am_value_t AM_LANE [N_ALIGNER] = '{
		48'hC168213E97DE,
		48'h9D718E628E71,
		48'h594BE8A6B417,
		48'h4D957BB26A84,
		48'hF507090AF8F6,
		48'hDD14C222EB3D,
		48'h9A4A2665B5D9,
		48'h7B456684BA99,
		48'hA024765FDB89,
		48'h68C9FB973604,
		48'hFD6C99029366,
		48'hB99155466EAA,
		48'h5CB9B2A3464D,
		48'h1AF8BDE50742,
		48'h83C7CA7C3835,
		48'h3536CDCAC932,
		48'hC4314C3BCEB3,
		48'hADD6B7522948,
		48'h5F662AA099D5,
		48'hC0F0E53F0F1A
	};

endpackage

// File: am_cmp_if.sv
`timescale 1ns/1ps

interface am_cmp_if;

	logic                   enable_mask;   // accept a marker at any position
	logic                   timer_done;    // marker position reached
	am_lock_pkg::lane_vec_t match_mask;    // lanes allowed to match
	logic                   am_match;
	am_lock_pkg::lane_vec_t match_vector;  // one bit per matching lane

	modport fsm
	(
		output enable_mask,
		output match_mask,
		input  am_match,
		input  match_vector
	);

	modport cmp
	(
		input  enable_mask,
		input  timer_done,
		input  match_mask,
		output am_match,
		output match_vector
	);

endinterface

// File: am_lock_comparator.sv
`timescale 1ns/1ps

module am_lock_comparator
(
	input  am_lock_pkg::am_value_t i_am_value,
	input  logic                   i_candidate,
	input  am_lock_pkg::am_value_t i_compare_mask,
	am_cmp_if.cmp                  u_cmp
);

	am_lock_pkg::am_value_t am_masked;
	am_lock_pkg::lane_vec_t lane_hit;
	logic                   enable;
	logic                   any_hit;

	assign am_masked = i_am_value & i_compare_mask;

	// masked compare against every lane constant
	always_comb
	begin
		for (int i = 0; i < am_lock_pkg::N_ALIGNER; i++)
		begin
			lane_hit[i] = (am_masked == (am_lock_pkg::AM_LANE[i] & i_compare_mask));
		end
	end

	assign u_cmp.match_vector = lane_hit & u_cmp.match_mask;  // only expected lanes
	assign any_hit = |u_cmp.match_vector;

	// searching, or the period has run out
	assign enable = u_cmp.enable_mask | u_cmp.timer_done;

	assign u_cmp.am_match = any_hit & enable & i_candidate;

endmodule

// File: am_block_timer.sv
`timescale 1ns/1ps

module am_block_timer
(
	input  logic i_clock,
	input  logic i_rst,
	input  logic i_valid,
	input  logic i_restart,
	output logic o_timer_done
);

	am_lock_pkg::timer_t count;
	logic                armed;  // set by the first restart
	logic                at_last;

	assign at_last = (count == am_lock_pkg::timer_t'(am_lock_pkg::AM_PERIOD - 1));

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			count <= '0;
			armed <= 1'b0;
		end
		else if (i_valid)
		begin
			if (i_restart)
			begin
				count <= '0;  // restarting block is position zero
				armed <= 1'b1;
			end
			else if (armed)
			begin
				if (at_last)
					count <= '0;  // next period starts by itself
				else
					count <= count + 1'b1;
			end
		end
	end

	// only valid blocks advance the count, idle cycles are skipped
	assign o_timer_done = armed & i_valid & at_last;

endmodule

// File: am_lock_fsm.sv
`timescale 1ns/1ps

module am_lock_fsm
(
	input  logic                  i_clock,
	input  logic                  i_rst,
	input  logic                  i_candidate,
	input  logic                  i_timer_done,
	am_cmp_if.fsm                 u_cmp,
	output logic                  o_timer_restart,
	output logic                  o_am_lock,
	output am_lock_pkg::lane_id_t o_lane_id,
	output logic                  o_am_found
);

	am_lock_pkg::lock_state_e                     state;
	logic [$clog2(am_lock_pkg::LOCK_GOOD+1)-1:0] good_cnt;
	logic [$clog2(am_lock_pkg::LOSS_BAD+1)-1:0]  bad_cnt;
	logic                                         good;
	logic                                         searching;

	// lowest set lane wins
	function automatic am_lock_pkg::lane_id_t lane_encode(input am_lock_pkg::lane_vec_t vec);
		am_lock_pkg::lane_id_t idx;
		idx = '0;
		for (int i = am_lock_pkg::N_ALIGNER - 1; i >= 0; i--)
		begin
			if (vec[i])
				idx = am_lock_pkg::lane_id_t'(i);
		end
		return idx;
	endfunction

	assign searching = (state == am_lock_pkg::ST_SEARCH);
	assign good      = i_candidate & u_cmp.am_match;

	assign u_cmp.enable_mask = searching;
	assign u_cmp.match_mask  = searching ? '1 :
		(am_lock_pkg::lane_vec_t'(1) << o_lane_id);  // recorded lane only

	// first marker in search anchors the period
	assign o_timer_restart = searching & good;

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			state      <= am_lock_pkg::ST_SEARCH;
			o_am_lock  <= 1'b0;
			o_am_found <= 1'b0;
			o_lane_id  <= '0;
			good_cnt   <= '0;
			bad_cnt    <= '0;
		end
		else
		begin
			o_am_found <= 1'b0;
			case (state)
				am_lock_pkg::ST_SEARCH:
				begin
					if (good)
					begin
						o_lane_id  <= lane_encode(u_cmp.match_vector);
						o_am_found <= 1'b1;
						good_cnt   <= 1'b1;
						state      <= am_lock_pkg::ST_CONFIRM;
					end
				end
				am_lock_pkg::ST_CONFIRM:
				begin
					if (i_timer_done)
					begin
						if (good)
						begin
							o_am_found <= 1'b1;
							good_cnt   <= good_cnt + 1'b1;
							if (int'(good_cnt) + 1 >= am_lock_pkg::LOCK_GOOD)
							begin
								o_am_lock <= 1'b1;
								state     <= am_lock_pkg::ST_LOCKED;
							end
						end
						else
						begin
							good_cnt <= '0;  // start over
							state    <= am_lock_pkg::ST_SEARCH;
						end
					end
				end
				am_lock_pkg::ST_LOCKED:
				begin
					if (i_timer_done)
					begin
						if (good)
							o_am_found <= 1'b1;
						else
						begin
							bad_cnt <= 1'b1;  // first bad one
							state   <= am_lock_pkg::ST_INVALID;
						end
					end
				end
				am_lock_pkg::ST_INVALID:
				begin
					if (i_timer_done)
					begin
						if (good)
						begin
							o_am_found <= 1'b1;
							bad_cnt    <= '0;
							state      <= am_lock_pkg::ST_LOCKED;
						end
						else if (int'(bad_cnt) + 1 >= am_lock_pkg::LOSS_BAD)
						begin
							o_am_lock <= 1'b0;  // lock lost
							bad_cnt   <= '0;
							good_cnt  <= '0;
							state     <= am_lock_pkg::ST_SEARCH;
						end
						else
							bad_cnt <= bad_cnt + 1'b1;
					end
				end
				default:
					state <= am_lock_pkg::ST_SEARCH;
			endcase
		end
	end

endmodule

// File: am_lock_top.sv
`timescale 1ns/1ps

module am_lock_top
(
	input  logic                   i_clock,
	input  logic                   i_rst,
	input  logic                   i_valid,
	input  am_lock_pkg::sync_hdr_t i_sync_header,
	input  am_lock_pkg::block_t    i_data,
	input  am_lock_pkg::am_value_t i_compare_mask,
	output logic                   o_am_lock,
	output am_lock_pkg::lane_id_t  o_lane_id,
	output logic                   o_am_found
);

	am_lock_pkg::am_value_t am_value;
	logic                   candidate;
	logic                   timer_restart;
	logic                   timer_done;

	am_cmp_if u_cmp_if ();

	// byte 0 sits in i_data[7:0], BIP3 and BIP7 are dropped
	assign am_value = {i_data[7:0], i_data[15:8], i_data[23:16],
		i_data[39:32], i_data[47:40], i_data[55:48]};

	assign candidate = i_valid & (i_sync_header == am_lock_pkg::SH_CTRL);  // control blocks only

	assign u_cmp_if.timer_done = timer_done;

	am_lock_comparator u_comparator
	(
		.i_am_value     (am_value),
		.i_candidate    (candidate),
		.i_compare_mask (i_compare_mask),
		.u_cmp          (u_cmp_if.cmp)
	);

	am_block_timer u_timer
	(
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_valid      (i_valid),
		.i_restart    (timer_restart),
		.o_timer_done (timer_done)
	);

	am_lock_fsm u_fsm
	(
		.i_clock         (i_clock),
		.i_rst           (i_rst),
		.i_candidate     (candidate),
		.i_timer_done    (timer_done),
		.u_cmp           (u_cmp_if.fsm),
		.o_timer_restart (timer_restart),
		.o_am_lock       (o_am_lock),
		.o_lane_id       (o_lane_id),
		.o_am_found      (o_am_found)
	);

endmodule

// File: am_lock_props.sv
`timescale 1ns/1ps

module am_lock_props
(
	input logic                     i_clock,
	input logic                     i_rst,
	input logic                     i_candidate,
	input am_lock_pkg::lock_state_e i_state,
	input logic                     i_am_lock,
	input am_lock_pkg::lane_id_t    i_lane_id,
	input logic                     i_am_found
);

	// lock must be clear on the first edge after a reset cycle
	lock_low_after_reset: assert property (@(posedge i_clock) $past(i_rst) |-> !i_am_lock)
		else $error("lock high right after reset");

	lane_stable_in_lock: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_am_lock && $past(i_am_lock)) |-> $stable(i_lane_id))
		else $error("lane id changed while locked");

	found_needs_candidate: assert property (@(posedge i_clock) disable iff (i_rst)
		i_am_found |-> $past(i_candidate))  // found is registered
		else $error("marker found without a control block");

	no_direct_lock: assert property (@(posedge i_clock) disable iff (i_rst)
		($past(i_state) == am_lock_pkg::ST_SEARCH) |-> (i_state != am_lock_pkg::ST_LOCKED))
		else $error("search jumped straight to locked");

endmodule

bind am_lock_fsm am_lock_props u_props
(
	.i_clock     (i_clock),
	.i_rst       (i_rst),
	.i_candidate (i_candidate),
	.i_state     (state),
	.i_am_lock   (o_am_lock),
	.i_lane_id   (o_lane_id),
	.i_am_found  (o_am_found)
);

// File: tb_am_lock.sv
`timescale 1ns/1ps

module tb_am_lock;

	localparam int N_ROWS   = 32;
	localparam int MAX_MARK = 8;
	localparam int TIMEOUT  = 2 * am_lock_pkg::AM_PERIOD;
	localparam am_lock_pkg::am_value_t FULL_MASK = '1;
	localparam am_lock_pkg::am_value_t M1_CLEAR  = 48'hFF00_FFFF_FFFF;  // ignore byte M1

	logic                   i_clock;
	logic                   i_rst;
	logic                   i_valid;
	am_lock_pkg::sync_hdr_t i_sync_header;
	am_lock_pkg::block_t    i_data;
	am_lock_pkg::am_value_t i_compare_mask;
	logic                   o_am_lock;
	am_lock_pkg::lane_id_t  o_lane_id;
	logic                   o_am_found;

	// bit k of a flag field selects marker k
	string                  row_name  [N_ROWS];
	int                     row_lane  [N_ROWS];
	int                     row_count [N_ROWS];
	logic [MAX_MARK-1:0]    row_bip   [N_ROWS];  // flip one BIP byte
	logic [MAX_MARK-1:0]    row_byte  [N_ROWS];  // flip marker byte M1
	logic [MAX_MARK-1:0]    row_alt   [N_ROWS];  // send the next lane's marker
	am_lock_pkg::am_value_t row_mask  [N_ROWS];
	logic                   row_lock  [N_ROWS];
	int                     row_id    [N_ROWS];

	integer                   seed;
	int                       n_rows;
	int                       n_pass;
	int                       n_fail;
	int                       row_errors;
	int                       ref_good;  // good markers in a row before lock
	int                       ref_lane;
	int                       ref_bad;
	logic                     ref_lock;
	logic                     ref_found;

	am_lock_top u_dut
	(
		.i_clock        (i_clock),
		.i_rst          (i_rst),
		.i_valid        (i_valid),
		.i_sync_header  (i_sync_header),
		.i_data         (i_data),
		.i_compare_mask (i_compare_mask),
		.o_am_lock      (o_am_lock),
		.o_lane_id      (o_lane_id),
		.o_am_found     (o_am_found)
	);

	always #5 i_clock = ~i_clock;

	task automatic add_row(input string name, input int lane, input int count,
		input logic [MAX_MARK-1:0] bip, input logic [MAX_MARK-1:0] byt,
		input logic [MAX_MARK-1:0] alt, input am_lock_pkg::am_value_t mask,
		input logic lock, input int id);
		row_name[n_rows]  = name;
		row_lane[n_rows]  = lane;
		row_count[n_rows] = count;
		row_bip[n_rows]   = bip;
		row_byte[n_rows]  = byt;
		row_alt[n_rows]   = alt;
		row_mask[n_rows]  = mask;
		row_lock[n_rows]  = lock;
		row_id[n_rows]    = id;
		n_rows++;
	endtask

	task automatic build_table();
		for (int i = 0; i < am_lock_pkg::N_ALIGNER; i++)
			add_row($sformatf("lane_%0d", i), i, 2, 8'h00, 8'h00, 8'h00,
				FULL_MASK, 1'b1, i);
		add_row("bip_ignored", 5, 3, 8'h07, 8'h00, 8'h00, FULL_MASK, 1'b1, 5);
		add_row("mask_byte_cleared", 7, 2, 8'h00, 8'h03, 8'h00, M1_CLEAR, 1'b1, 7);
		add_row("mask_full_fails", 7, 2, 8'h00, 8'h02, 8'h00, FULL_MASK, 1'b0, 7);
		add_row("confirm_fail", 3, 4, 8'h00, 8'h02, 8'h00, FULL_MASK, 1'b1, 3);
		add_row("three_bad_kept", 11, 6, 8'h00, 8'h1C, 8'h00, FULL_MASK, 1'b1, 11);
		add_row("four_bad_lost", 11, 6, 8'h00, 8'h3C, 8'h00, FULL_MASK, 1'b0, 11);
		add_row("wrong_lane_bad", 9, 6, 8'h00, 8'h00, 8'h3C, FULL_MASK, 1'b0, 9);
	endtask

	// byte k of the payload sits in bits 8k+7:8k
	function automatic am_lock_pkg::block_t marker_block(input am_lock_pkg::am_value_t am,
		input logic [7:0] bip3, input logic [7:0] bip7);
		return {bip7, am[7:0], am[15:8], am[23:16], bip3, am[31:24], am[39:32], am[47:40]};
	endfunction

	function automatic am_lock_pkg::block_t payload();
		return {$random(seed), $random(seed)};
	endfunction

	// every bit under the mask agrees with the lane marker
	function automatic logic lane_hit(input am_lock_pkg::am_value_t am,
		input am_lock_pkg::am_value_t mask, input int lane);
		return ((am ^ am_lock_pkg::AM_LANE[lane]) & mask) == '0;
	endfunction

	// expected outcome of one marker at its due position
	task automatic model_marker(input am_lock_pkg::am_value_t am,
		input am_lock_pkg::am_value_t mask);
		int hit;
		hit = -1;
		for (int i = 0; i < am_lock_pkg::N_ALIGNER; i++)
			if ((hit < 0) && lane_hit(am, mask, i))
				hit = i;
		ref_found = 1'b0;
		if (ref_lock)
		begin
			if (lane_hit(am, mask, ref_lane))
			begin
				ref_found = 1'b1;
				ref_bad   = 0;
			end
			else
			begin
				ref_bad++;
				if (ref_bad == am_lock_pkg::LOSS_BAD)
				begin
					ref_lock = 1'b0;
					ref_bad  = 0;
				end
			end
		end
		else if (ref_good > 0)
		begin
			if (lane_hit(am, mask, ref_lane))
			begin
				ref_found = 1'b1;
				ref_good++;
				if (ref_good == am_lock_pkg::LOCK_GOOD)
				begin
					ref_lock = 1'b1;
					ref_good = 0;
				end
			end
			else
				ref_good = 0;  // hunt again
		end
		else if (hit >= 0)
		begin
			ref_lane  = hit;
			ref_found = 1'b1;
			ref_good  = 1;
		end
	endtask

	task automatic apply_reset();
		@(negedge i_clock);
		i_rst   = 1'b1;
		i_valid = 1'b0;
		repeat (3) @(negedge i_clock);
		i_rst = 1'b0;
	endtask

	// idle cycles come at random and never count as blocks
	task automatic send_block(input am_lock_pkg::sync_hdr_t hdr,
		input am_lock_pkg::block_t data);
		logic [31:0] r;
		r = $random(seed);
		if (r[5:0] == 6'd0)
		begin
			@(negedge i_clock);
			i_valid       = 1'b0;
			i_sync_header = 2'b01;
		end
		@(negedge i_clock);
		i_valid       = 1'b1;
		i_sync_header = hdr;
		i_data        = data;
	endtask

	task automatic report_mismatch(input string name, input string what,
		input int exp, input int act);
		$display("[FAIL] %s %s expected %0d actual %0d", name, what, exp, act);
		row_errors++;
	endtask

	task automatic run_row(input int idx);
		am_lock_pkg::am_value_t am;
		logic [7:0]             bip3;
		logic [7:0]             bip7;
		int                     lane;
		int                     waited;
		row_errors     = 0;
		i_compare_mask = row_mask[idx];
		apply_reset();
		ref_good = 0;
		ref_lane = 0;
		ref_bad  = 0;
		ref_lock = 1'b0;
		for (int k = 0; k < 4; k++)
			send_block(2'b01, payload());  // lead-in before the first marker
		for (int k = 0; k < row_count[idx]; k++)
		begin
			lane = row_alt[idx][k] ? (row_lane[idx] + 1) % am_lock_pkg::N_ALIGNER
				: row_lane[idx];
			am   = am_lock_pkg::AM_LANE[lane];
			if (row_byte[idx][k])
				am[39:32] = ~am[39:32];
			bip3 = 8'h5A;
			bip7 = 8'hA5;
			if (row_bip[idx][k] && (k % 2 == 0))
				bip3 = ~bip3;
			else if (row_bip[idx][k])
				bip7 = ~bip7;
			send_block(am_lock_pkg::SH_CTRL, marker_block(am, bip3, bip7));
			model_marker(am, row_mask[idx]);
			@(negedge i_clock);  // outputs one cycle after the marker
			assert (o_am_found == ref_found)
				else report_mismatch(row_name[idx], $sformatf("marker %0d o_am_found", k),
					ref_found, o_am_found);
			assert (o_am_lock == ref_lock)
				else report_mismatch(row_name[idx], $sformatf("marker %0d o_am_lock", k),
					ref_lock, o_am_lock);
			assert (int'(o_lane_id) == ref_lane)
				else report_mismatch(row_name[idx], $sformatf("marker %0d o_lane_id", k),
					ref_lane, o_lane_id);
			i_sync_header = 2'b01;
			i_data        = payload();  // first block of the gap
			if (k < row_count[idx] - 1)
				for (int g = 0; g < am_lock_pkg::AM_PERIOD - 2; g++)
					send_block(2'b01, payload());
		end
		i_valid = 1'b0;
		waited  = 0;
		while ((o_am_lock !== row_lock[idx]) && (waited < TIMEOUT))
		begin
			@(negedge i_clock);
			waited++;
		end
		if (waited >= TIMEOUT)
		begin
			$display("[FAIL] %s lock never reached its final value in time", row_name[idx]);
			row_errors++;
		end
		assert (o_am_lock == row_lock[idx])
			else report_mismatch(row_name[idx], "final o_am_lock", row_lock[idx], o_am_lock);
		assert (int'(o_lane_id) == row_id[idx])
			else report_mismatch(row_name[idx], "final o_lane_id", row_id[idx], o_lane_id);
		if (row_errors == 0)
		begin
			$display("[PASS] %s", row_name[idx]);
			n_pass++;
		end
		else
		begin
			$display("[FAIL] %s finished with %0d bad checks", row_name[idx], row_errors);
			n_fail++;
		end
	endtask

	initial
	begin
		i_clock        = 1'b0;
		i_rst          = 1'b1;
		i_valid        = 1'b0;
		i_sync_header  = 2'b01;
		i_data         = '0;
		i_compare_mask = FULL_MASK;
		seed           = 70;
		n_rows         = 0;
		n_pass         = 0;
		n_fail         = 0;
		build_table();
		for (int r = 0; r < n_rows; r++)
			run_row(r);
		$display("tests %0d, passed %0d, failed %0d", n_rows, n_pass, n_fail);
		if (n_fail == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: src.f
am_lock_pkg.sv
am_cmp_if.sv
am_lock_comparator.sv
am_block_timer.sv
am_lock_fsm.sv
am_lock_top.sv
am_lock_props.sv
tb_am_lock.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_am_lock
FILELIST = src.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
